// File: cpu_pkg.sv
// shared widths and encodings; any opcode/op pair not listed here halts the processor
package cpu_pkg;

	localparam int word_width = 16;
	localparam int addr_width = 9; // word address, 512 words
	localparam int reg_count = 8;
	localparam int reg_num_width = 3;

	// instruction field positions
	localparam int opcode_lsb = 13;
	localparam int op_lsb = 11;
	localparam int rn_lsb = 8;
	localparam int rd_lsb = 5;
	localparam int shift_lsb = 3;
	localparam int rm_lsb = 0;
	localparam int imm8_width = 8; // imm8 is bits 7..0
	localparam int imm5_width = 5; // imm5 is bits 4..0

	typedef enum logic [1:0] {
		mem_none  = 2'b00,
		mem_read  = 2'b01,
		mem_write = 2'b10
	} mem_cmd_t;

	typedef enum logic [2:0] {
		op_load  = 3'b011,
		op_store = 3'b100,
		op_alu   = 3'b101,
		op_move  = 3'b110,
		op_halt  = 3'b111
	} opcode_t;

	typedef enum logic [1:0] {
		alu_add = 2'b00,
		alu_cmp = 2'b01,
		alu_and = 2'b10,
		alu_mvn = 2'b11
	} alu_op_t;

	// the op field also carries the MOV form and must be add for load/store
	localparam alu_op_t mov_sub_imm = alu_and;
	localparam alu_op_t mov_sub_reg = alu_add;
	localparam alu_op_t ldst_sub = alu_add; // address is Rn + imm5

	typedef enum logic [1:0] {
		shift_none          = 2'b00,
		shift_left          = 2'b01,
		shift_right_logical = 2'b10,
		shift_right_arith   = 2'b11
	} shift_t;

	typedef enum logic [2:0] {
		nsel_none = 3'b000, // no register selected
		nsel_rn   = 3'b001,
		nsel_rd   = 3'b010,
		nsel_rm   = 3'b100
	} nsel_t;

	typedef enum logic [1:0] {
		vsel_c     = 2'b00,
		vsel_imm8  = 2'b01,
		vsel_mdata = 2'b10
	} vsel_t;

	// upper three bits name the sequence, lower three the step within it
	typedef enum logic [5:0] {
		st_reset     = 6'b000_000,
		st_fetch1    = 6'b000_001,
		st_fetch2    = 6'b000_010,
		st_update_pc = 6'b000_011,
		st_mov_imm   = 6'b001_000,
		st_shift1    = 6'b010_000, // MOV register and MVN
		st_shift2    = 6'b010_001,
		st_shift3    = 6'b010_010,
		st_alu1      = 6'b011_000, // ADD and AND
		st_alu2      = 6'b011_001,
		st_alu3      = 6'b011_010,
		st_alu4      = 6'b011_011,
		st_cmp1      = 6'b100_000,
		st_cmp2      = 6'b100_001,
		st_cmp3      = 6'b100_010,
		st_ldr1      = 6'b101_000,
		st_ldr2      = 6'b101_001,
		st_ldr3      = 6'b101_010,
		st_ldr4      = 6'b101_011,
		st_ldr5      = 6'b101_100,
		st_ldr6      = 6'b101_101,
		st_str1      = 6'b110_000,
		st_str2      = 6'b110_001,
		st_str3      = 6'b110_010,
		st_str4      = 6'b110_011,
		st_str5      = 6'b110_100,
		st_str6      = 6'b110_101,
		st_halt      = 6'b111_000
	} ctrl_state_t;

endpackage

// File: cpu_decoder.sv
// combinational only; the shift field is ignored on load/store, where it is part of imm5
`timescale 1ns/1ps

module cpu_decoder
	import cpu_pkg::*;
(
	input  logic [word_width-1:0]    instr,
	input  nsel_t                    nsel,
	output logic [reg_num_width-1:0] reg_num,
	output alu_op_t                  alu_op,
	output shift_t                   shift,
	output logic [word_width-1:0]    sximm5,
	output logic [word_width-1:0]    sximm8,
	output opcode_t                  opcode,
	output alu_op_t                  op
);

	logic [reg_num_width-1:0] rn;
	logic [reg_num_width-1:0] rd;
	logic [reg_num_width-1:0] rm;

	assign opcode = opcode_t'(instr[opcode_lsb +: 3]);
	assign op = alu_op_t'(instr[op_lsb +: 2]);
	assign alu_op = op; // same field drives the ALU

	assign rn = instr[rn_lsb +: reg_num_width];
	assign rd = instr[rd_lsb +: reg_num_width];
	assign rm = instr[rm_lsb +: reg_num_width];

	// imm5 overlaps the shift bits, so only register forms shift
	assign shift = (opcode == op_alu || opcode == op_move) ?
		shift_t'(instr[shift_lsb +: 2]) : shift_none;

	assign sximm8 = {{(word_width-imm8_width){instr[imm8_width-1]}}, instr[imm8_width-1:0]};
	assign sximm5 = {{(word_width-imm5_width){instr[imm5_width-1]}}, instr[imm5_width-1:0]};

	always_comb begin
		case (nsel)
			nsel_rd: reg_num = rd;
			nsel_rm: reg_num = rm;
			default: reg_num = rn; // rn also when idle
		endcase
	end

	// the controller must never select two register fields at once
	always_comb begin
		if (nsel != nsel_none)
			assert ($onehot(nsel)) else $error("register select is not one-hot");
	end

endmodule

// File: register_file.sv
// no reset on the registers, software must write a register before reading it
`timescale 1ns/1ps

module register_file
	import cpu_pkg::*;
(
	input  logic                     clk,
	input  logic                     write,
	input  logic [reg_num_width-1:0] reg_num,
	input  logic [word_width-1:0]    data_in,
	output logic [word_width-1:0]    data_out
);

	logic [word_width-1:0] regs [reg_count];

	always_ff @(posedge clk) begin
		if (write)
			regs[reg_num] <= data_in; // write-back at the edge
	end

	// read and write share one index, read is combinational
	assign data_out = regs[reg_num];

endmodule

// File: alu_shifter.sv
// single-bit shifts only; v is meaningful only for the CMP subtraction, zero for the other operations
`timescale 1ns/1ps

module alu_shifter
	import cpu_pkg::*;
(
	input  logic [word_width-1:0] a,
	input  logic [word_width-1:0] b,
	input  logic [word_width-1:0] imm,
	input  logic                  asel,
	input  logic                  bsel,
	input  shift_t                shift,
	input  alu_op_t               alu_op,
	output logic [word_width-1:0] result,
	output logic                  n_next,
	output logic                  v_next,
	output logic                  z_next
);

	localparam int msb = word_width - 1;

	logic [word_width-1:0] a_in;
	logic [word_width-1:0] b_shifted;
	logic [word_width-1:0] b_in;

	always_comb begin
		case (shift)
			shift_left:          b_shifted = {b[msb-1:0], 1'b0};
			shift_right_logical: b_shifted = {1'b0, b[msb:1]};
			shift_right_arith:   b_shifted = {b[msb], b[msb:1]}; // keeps sign
			default:             b_shifted = b;
		endcase
	end

	assign a_in = asel ? '0 : a; // zero A for moves
	assign b_in = bsel ? imm : b_shifted;

	always_comb begin
		v_next = 1'b0;
		case (alu_op)
			alu_add: result = a_in + b_in;
			alu_cmp: begin
				result = a_in - b_in;
				v_next = (a_in[msb] != b_in[msb]) && (result[msb] != a_in[msb]);
			end
			alu_and: result = a_in & b_in;
			default: result = ~b_in; // mvn
		endcase
	end

	assign n_next = result[msb];
	assign z_next = (result == '0);

endmodule

// File: cpu_datapath.sv
// operand and status registers hold no reset value, flags are undefined until the first CMP
`timescale 1ns/1ps

module cpu_datapath
	import cpu_pkg::*;
(
	input  logic                     clk,
	input  logic [reg_num_width-1:0] reg_num,
	input  vsel_t                    vsel,
	input  logic                     loada,
	input  logic                     loadb,
	input  logic                     loadc,
	input  logic                     loads,
	input  logic                     asel,
	input  logic                     bsel,
	input  logic                     write,
	input  alu_op_t                  alu_op,
	input  shift_t                   shift,
	input  logic [word_width-1:0]    mdata,
	input  logic [word_width-1:0]    sximm8,
	input  logic [word_width-1:0]    sximm5,
	output logic [word_width-1:0]    datapath_out,
	output logic                     n,
	output logic                     v,
	output logic                     z
);

	logic [word_width-1:0] reg_out;
	logic [word_width-1:0] wb_data;
	logic [word_width-1:0] a_reg;
	logic [word_width-1:0] b_reg;
	logic [word_width-1:0] c_reg;
	logic [word_width-1:0] alu_result;
	logic n_next;
	logic v_next;
	logic z_next;

	always_comb begin
		case (vsel)
			vsel_imm8:  wb_data = sximm8;
			vsel_mdata: wb_data = mdata; // load data from memory
			default:    wb_data = c_reg;
		endcase
	end

	register_file i_regs (
		.clk      (clk),
		.write    (write),
		.reg_num  (reg_num),
		.data_in  (wb_data),
		.data_out (reg_out)
	);

	always_ff @(posedge clk) begin
		if (loada)
			a_reg <= reg_out;
		if (loadb)
			b_reg <= reg_out;
		if (loadc)
			c_reg <= alu_result;
		if (loads) begin
			n <= n_next;
			v <= v_next;
			z <= z_next;
		end
	end

	alu_shifter i_alu (
		.a      (a_reg),
		.b      (b_reg),
		.imm    (sximm5), // only load/store use an ALU immediate
		.asel   (asel),
		.bsel   (bsel),
		.shift  (shift),
		.alu_op (alu_op),
		.result (alu_result),
		.n_next (n_next),
		.v_next (v_next),
		.z_next (z_next)
	);

	assign datapath_out = c_reg; // store data and address source

endmodule

// File: cpu_controller.sv
// fixed-latency memory assumed, no wait states; halt holds until reset
`timescale 1ns/1ps

module cpu_controller
	import cpu_pkg::*;
(
	input  logic     clk,
	input  logic     reset,
	input  opcode_t  opcode,
	input  alu_op_t  op,
	output nsel_t    nsel,
	output vsel_t    vsel,
	output logic     loada,
	output logic     loadb,
	output logic     loadc,
	output logic     loads,
	output logic     asel,
	output logic     bsel,
	output logic     write,
	output logic     load_ir,
	output logic     load_pc,
	output logic     reset_pc,
	output logic     addr_sel,
	output logic     load_addr,
	output mem_cmd_t mem_cmd,
	output logic     halted
);

	ctrl_state_t state;
	ctrl_state_t state_next;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= st_reset;
			halted <= 1'b0;
		end else begin
			state <= state_next;
			halted <= (state == st_halt); // one cycle after entering halt
		end
	end

	always_comb begin
		case (state)
			st_reset:     state_next = st_fetch1;
			st_fetch1:    state_next = st_fetch2;
			st_fetch2:    state_next = st_update_pc;
			st_update_pc: begin
				case (opcode)
					op_move:  state_next = (op == mov_sub_imm) ? st_mov_imm :
						(op == mov_sub_reg) ? st_shift1 : st_halt;
					op_alu:   state_next = (op == alu_cmp) ? st_cmp1 :
						(op == alu_mvn) ? st_shift1 : st_alu1;
					op_load:  state_next = (op == ldst_sub) ? st_ldr1 : st_halt;
					op_store: state_next = (op == ldst_sub) ? st_str1 : st_halt;
					default:  state_next = st_halt; // HALT and undefined codes
				endcase
			end
			st_shift1: state_next = st_shift2;
			st_shift2: state_next = st_shift3;
			st_alu1:   state_next = st_alu2;
			st_alu2:   state_next = st_alu3;
			st_alu3:   state_next = st_alu4;
			st_cmp1:   state_next = st_cmp2;
			st_cmp2:   state_next = st_cmp3;
			st_ldr1:   state_next = st_ldr2;
			st_ldr2:   state_next = st_ldr3;
			st_ldr3:   state_next = st_ldr4;
			st_ldr4:   state_next = st_ldr5;
			st_ldr5:   state_next = st_ldr6;
			st_str1:   state_next = st_str2;
			st_str2:   state_next = st_str3;
			st_str3:   state_next = st_str4;
			st_str4:   state_next = st_str5;
			st_str5:   state_next = st_str6;
			st_mov_imm, st_shift3, st_alu4, st_cmp3, st_ldr6, st_str6:
				state_next = st_fetch1; // last execute step
			default:   state_next = st_halt;
		endcase
	end

	always_comb begin
		nsel = nsel_none;
		vsel = vsel_c;
		loada = 1'b0;
		loadb = 1'b0;
		loadc = 1'b0;
		loads = 1'b0;
		asel = 1'b0;
		bsel = 1'b0;
		write = 1'b0;
		load_ir = 1'b0;
		load_pc = 1'b0;
		reset_pc = 1'b0;
		addr_sel = 1'b0;
		load_addr = 1'b0;
		mem_cmd = mem_none;
		case (state)
			st_reset: begin
				reset_pc = 1'b1;
				load_pc = 1'b1;
			end
			st_fetch1: begin
				mem_cmd = mem_read;
				addr_sel = 1'b1;
			end
			st_fetch2: begin
				mem_cmd = mem_read;
				addr_sel = 1'b1;
				load_ir = 1'b1; // read data valid this cycle
			end
			st_update_pc: begin
				mem_cmd = mem_read;
				addr_sel = 1'b1;
				load_pc = 1'b1;
			end
			st_mov_imm: begin
				nsel = nsel_rn;
				vsel = vsel_imm8;
				write = 1'b1;
			end
			st_alu1, st_cmp1, st_ldr1, st_str1: begin
				nsel = nsel_rn;
				loada = 1'b1;
			end
			st_shift1, st_alu2, st_cmp2: begin
				nsel = nsel_rm;
				loadb = 1'b1;
			end
			st_shift2, st_str5: begin
				asel = 1'b1; // C = 0 + B, or not B
				loadc = 1'b1;
			end
			st_alu3: loadc = 1'b1;
			st_shift3, st_alu4: begin
				nsel = nsel_rd;
				write = 1'b1;
			end
			st_cmp3: loads = 1'b1; // only place the flags change
			st_ldr2, st_str2: begin
				bsel = 1'b1; // C = Rn + imm5
				loadc = 1'b1;
			end
			st_ldr3, st_str3: load_addr = 1'b1;
			st_ldr4, st_ldr5: mem_cmd = mem_read;
			st_ldr6: begin
				mem_cmd = mem_read;
				nsel = nsel_rd;
				vsel = vsel_mdata;
				write = 1'b1;
			end
			st_str4: begin
				nsel = nsel_rd;
				loadb = 1'b1;
			end
			st_str6: mem_cmd = mem_write;
			default: ; // halt drives nothing
		endcase
	end

	a_mem_cmd_legal: assert property (@(posedge clk) disable iff (reset)
		mem_cmd != 2'b11) else $error("unused memory command code driven");

	a_no_write_clash: assert property (@(posedge clk) disable iff (reset)
		!(write && mem_cmd == mem_write)) else $error("register and memory write together");

endmodule

// File: cpu.sv
// single memory port with one-cycle read latency; PC is cleared by the reset step, not by reset
`timescale 1ns/1ps

module cpu
	import cpu_pkg::*;
(
	input  logic                  clk,
	input  logic                  reset,
	input  logic [word_width-1:0] read_data,
	output mem_cmd_t              mem_cmd,
	output logic [addr_width-1:0] mem_addr,
	output logic [word_width-1:0] write_data,
	output logic                  n,
	output logic                  v,
	output logic                  z,
	output logic                  halted
);

	logic [word_width-1:0] instr;
	logic [addr_width-1:0] pc;
	logic [addr_width-1:0] data_addr;
	logic [word_width-1:0] datapath_out;
	logic [word_width-1:0] sximm5;
	logic [word_width-1:0] sximm8;
	logic [reg_num_width-1:0] reg_num;
	nsel_t nsel;
	vsel_t vsel;
	opcode_t opcode;
	alu_op_t op;
	alu_op_t alu_op;
	shift_t shift;
	logic loada;
	logic loadb;
	logic loadc;
	logic loads;
	logic asel;
	logic bsel;
	logic write;
	logic load_ir;
	logic load_pc;
	logic reset_pc;
	logic addr_sel;
	logic load_addr;

	always_ff @(posedge clk) begin
		if (load_ir)
			instr <= read_data;
		if (load_pc)
			pc <= reset_pc ? '0 : pc + addr_width'(1);
		if (load_addr)
			data_addr <= datapath_out[addr_width-1:0]; // low bits of C
	end

	assign mem_addr = addr_sel ? pc : data_addr;
	assign write_data = datapath_out;

	cpu_controller i_ctrl (
		.clk       (clk),
		.reset     (reset),
		.opcode    (opcode),
		.op        (op),
		.nsel      (nsel),
		.vsel      (vsel),
		.loada     (loada),
		.loadb     (loadb),
		.loadc     (loadc),
		.loads     (loads),
		.asel      (asel),
		.bsel      (bsel),
		.write     (write),
		.load_ir   (load_ir),
		.load_pc   (load_pc),
		.reset_pc  (reset_pc),
		.addr_sel  (addr_sel),
		.load_addr (load_addr),
		.mem_cmd   (mem_cmd),
		.halted    (halted)
	);

	cpu_decoder i_dec (
		.instr   (instr),
		.nsel    (nsel),
		.reg_num (reg_num),
		.alu_op  (alu_op),
		.shift   (shift),
		.sximm5  (sximm5),
		.sximm8  (sximm8),
		.opcode  (opcode),
		.op      (op)
	);

	cpu_datapath i_dp (
		.clk          (clk),
		.reg_num      (reg_num),
		.vsel         (vsel),
		.loada        (loada),
		.loadb        (loadb),
		.loadc        (loadc),
		.loads        (loads),
		.asel         (asel),
		.bsel         (bsel),
		.write        (write),
		.alu_op       (alu_op),
		.shift        (shift),
		.mdata        (read_data),
		.sximm8       (sximm8),
		.sximm5       (sximm5),
		.datapath_out (datapath_out),
		.n            (n),
		.v            (v),
		.z            (z)
	);

endmodule

// File: tb_clock.sv
// 100 ns clock from time zero; synchronous reset held high for the first four rising edges
`timescale 1ns/1ps

module tb_clock (
	output logic clk,
	output logic reset
);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // half of the 100 ns period
	end

	initial begin
		reset <= 1'b1;
		repeat (4) @(posedge clk);
		reset <= 1'b0; // released at the fourth rising edge
	end

endmodule

// File: tb_cpu.sv
// random program must fit below word 384; loads and stores use words 400..495 only
`timescale 1ns/1ps

module tb_cpu
	import cpu_pkg::*;
();

	localparam int random_count = 60;
	localparam int store_every = 4;
	localparam int max_prog = 384;
	localparam logic [addr_width-1:0] prog_region = 9'd384; // fetches stay below this
	localparam int data_lo = 400;
	localparam int data_span = 96;
	localparam int halt_quiet = 20;

	logic clk;
	logic reset;
	logic [word_width-1:0] read_data;
	mem_cmd_t mem_cmd;
	logic [addr_width-1:0] mem_addr;
	logic [word_width-1:0] write_data;
	logic n;
	logic v;
	logic z;
	logic halted;

	logic [word_width-1:0] mem [1 << addr_width]; // memory seen by the DUT
	logic [word_width-1:0] prog [max_prog];
	logic [word_width-1:0] mregs [reg_count]; // reference model state
	logic [word_width-1:0] mmem [1 << addr_width];
	logic mn;
	logic mv;
	logic mz;
	logic flag_check [max_prog + 1]; // indexed by fetch number
	logic [2:0] exp_flags [max_prog + 1];
	logic [addr_width-1:0] exp_addr [$];
	logic [word_width-1:0] exp_data [$];
	int seed;
	int prog_len;
	int fetch_count;
	int store_index;
	int error_count;
	logic first_read_done;
	mem_cmd_t prev_cmd;
	logic [addr_width-1:0] prev_addr;

	tb_clock i_clock (
		.clk   (clk),
		.reset (reset)
	);

	cpu i_dut (
		.clk        (clk),
		.reset      (reset),
		.read_data  (read_data),
		.mem_cmd    (mem_cmd),
		.mem_addr   (mem_addr),
		.write_data (write_data),
		.n          (n),
		.v          (v),
		.z          (z),
		.halted     (halted)
	);

	// fixed one-cycle read latency, writes land at the edge
	always @(posedge clk) begin
		if (mem_cmd == mem_read)
			read_data <= mem[mem_addr];
		else if (mem_cmd == mem_write)
			mem[mem_addr] <= write_data;
	end

	function automatic int pick(input int span);
		logic [31:0] r;
		r = $random(seed);
		return int'(r % 32'(span));
	endfunction

	function automatic logic [word_width-1:0] fill_word(input logic [addr_width-1:0] a);
		return {a[6:0], a} ^ 16'ha5c3;
	endfunction

	function automatic logic [word_width-1:0] reg_word(input logic [2:0] opc,
			input logic [1:0] sub, input logic [2:0] rn, input logic [2:0] rd,
			input logic [1:0] sh, input logic [2:0] rm);
		logic [word_width-1:0] w;
		w = '0;
		w[opcode_lsb +: 3] = opc;
		w[op_lsb +: 2] = sub;
		w[rn_lsb +: 3] = rn;
		w[rd_lsb +: 3] = rd;
		w[shift_lsb +: 2] = sh;
		w[rm_lsb +: 3] = rm;
		return w;
	endfunction

	function automatic logic [word_width-1:0] mov_imm_word(input logic [2:0] rn,
			input logic [7:0] imm8);
		logic [word_width-1:0] w;
		w = reg_word(op_move, mov_sub_imm, rn, 3'd0, 2'd0, 3'd0);
		w[imm8_width-1:0] = imm8;
		return w;
	endfunction

	function automatic logic [word_width-1:0] mem_word(input logic [2:0] opc,
			input logic [2:0] rn, input logic [2:0] rd, input logic [4:0] imm5);
		logic [word_width-1:0] w;
		w = reg_word(opc, ldst_sub, rn, rd, 2'd0, 3'd0);
		w[imm5_width-1:0] = imm5; // offset covers the shift and Rm fields
		return w;
	endfunction

	function automatic logic [word_width-1:0] shift_operand(input logic [word_width-1:0] x,
			input shift_t sh);
		logic signed [word_width-1:0] sx;
		sx = x;
		case (sh)
			shift_left:          return x << 1;
			shift_right_logical: return x >> 1;
			shift_right_arith:   return sx >>> 1;
			default:             return x;
		endcase
	endfunction

	// ISA-level step of the reference model
	task automatic execute(input logic [word_width-1:0] w);
		logic [2:0] opc;
		logic [1:0] sub;
		logic [2:0] rn;
		logic [2:0] rd;
		logic [word_width-1:0] b;
		logic signed [7:0] imm8;
		logic signed [4:0] imm5;
		logic [addr_width-1:0] addr;
		logic signed [word_width-1:0] sa;
		logic signed [word_width-1:0] sb;
		int diff;
		opc = w[opcode_lsb +: 3];
		sub = w[op_lsb +: 2];
		rn = w[rn_lsb +: 3];
		rd = w[rd_lsb +: 3];
		imm8 = w[imm8_width-1:0];
		imm5 = w[imm5_width-1:0];
		b = shift_operand(mregs[w[rm_lsb +: 3]], shift_t'(w[shift_lsb +: 2]));
		addr = addr_width'(mregs[rn] + word_width'(imm5));
		case (opc)
			op_move: begin
				if (sub == mov_sub_imm)
					mregs[rn] = word_width'(imm8);
				else
					mregs[rd] = b;
			end
			op_alu: begin
				case (sub)
					alu_add: mregs[rd] = mregs[rn] + b;
					alu_and: mregs[rd] = mregs[rn] & b;
					alu_mvn: mregs[rd] = ~b;
					default: begin
						sa = mregs[rn];
						sb = b;
						diff = int'(sa) - int'(sb); // exact difference, no wrap
						mn = diff[word_width-1];
						mz = (diff[word_width-1:0] == '0);
						mv = (diff > 32767) || (diff < -32768);
					end
				endcase
			end
			op_load: mregs[rd] = mmem[addr];
			op_store: begin
				mmem[addr] = mregs[rd];
				exp_addr.push_back(addr);
				exp_data.push_back(mregs[rd]);
			end
			default: ;
		endcase
	endtask

	task automatic emit(input logic [word_width-1:0] w);
		prog[prog_len] = w;
		execute(w);
		prog_len++;
		if (w[opcode_lsb +: 3] == op_alu && w[op_lsb +: 2] == alu_cmp) begin
			flag_check[prog_len] = 1'b1; // flags seen at the next fetch
			exp_flags[prog_len] = {mn, mv, mz};
		end
	endtask

	// base register is loaded first so the address lands in the data region
	task automatic add_mem_op(input logic is_load, input logic [2:0] rd);
		logic [2:0] rn;
		logic signed [4:0] imm5;
		int target;
		int base;
		rn = 3'((int'(rd) + 1 + pick(7)) % reg_count);
		imm5 = 5'(pick(32));
		if (exp_addr.size() > 0 && pick(2) == 1)
			target = int'(exp_addr[pick(exp_addr.size())]); // reuse a stored word
		else
			target = data_lo + pick(data_span);
		base = target - 512 - int'(imm5);
		emit(mov_imm_word(rn, 8'(base)));
		emit(mem_word(is_load ? op_load : op_store, rn, rd, imm5));
	endtask

	task automatic add_random_instr();
		logic [2:0] rn;
		logic [2:0] rd;
		logic [2:0] rm;
		logic [1:0] sh;
		rn = 3'(pick(reg_count));
		rd = 3'(pick(reg_count));
		rm = 3'(pick(reg_count));
		sh = 2'(pick(4));
		case (pick(8))
			0: emit(mov_imm_word(rn, 8'(pick(256))));
			1: emit(reg_word(op_move, mov_sub_reg, rn, rd, sh, rm));
			2: emit(reg_word(op_alu, alu_add, rn, rd, sh, rm));
			3: emit(reg_word(op_alu, alu_and, rn, rd, sh, rm));
			4: emit(reg_word(op_alu, alu_mvn, rn, rd, sh, rm));
			5: emit(reg_word(op_alu, alu_cmp, rn, rd, sh, rm));
			6: begin
				add_mem_op(1'b1, rd);
				add_mem_op(1'b0, rd); // round trip of the loaded value
			end
			default: add_mem_op(1'b0, rd);
		endcase
	endtask

	task automatic build_program();
		prog_len = 0;
		for (int r = 0; r < reg_count; r++)
			emit(mov_imm_word(3'(r), 8'(pick(256))));
		for (int k = 0; k < random_count; k++) begin
			add_random_instr();
			if (k % store_every == store_every - 1)
				add_mem_op(1'b0, 3'(pick(reg_count)));
		end
		emit(reg_word(op_halt, 2'd0, 3'd0, 3'd0, 2'd0, 3'd0));
	endtask

	task automatic check_fetch();
		if (fetch_count >= prog_len) begin
			$display("Instruction fetched at address %0d after the HALT instruction", mem_addr);
			error_count++;
		end else begin
			if (mem_addr != addr_width'(fetch_count)) begin
				$display("Error at %0t: fetch %0d read address %0d, expected %0d",
					$time, fetch_count, mem_addr, fetch_count);
				error_count++;
			end
			if (flag_check[fetch_count] && {n, v, z} != exp_flags[fetch_count]) begin
				$display("Error at %0t: flags nvz %b%b%b after CMP, expected %b",
					$time, n, v, z, exp_flags[fetch_count]);
				error_count++;
			end
		end
		fetch_count++;
	endtask

	task automatic check_store();
		if (store_index >= exp_addr.size()) begin
			$display("Memory write to address %0d that the model never made", mem_addr);
			error_count++;
		end else if (mem_addr != exp_addr[store_index] ||
				write_data != exp_data[store_index]) begin
			$display("Error at %0t: store %0d wrote %h at %0d, expected %h at %0d", $time,
				store_index, write_data, mem_addr, exp_data[store_index], exp_addr[store_index]);
			error_count++;
		end
		store_index++;
	endtask

	// outputs are sampled mid-cycle, away from the driving edge
	always @(negedge clk) begin
		if (reset) begin
			if (mem_cmd != mem_none || halted) begin
				$display("Error at %0t: mem_cmd %0d halted %b during reset", $time, mem_cmd,
					halted);
				error_count++;
			end
		end else begin
			if (mem_cmd == mem_read && !first_read_done) begin
				first_read_done = 1'b1;
				if (mem_addr != '0) begin
					$display("Error at %0t: first read at %0d, expected 0", $time, mem_addr);
					error_count++;
				end
			end
			// a fetch 1 starts a new read run in the program region
			if (mem_cmd == mem_read && mem_addr < prog_region &&
					!(prev_cmd == mem_read && prev_addr == mem_addr))
				check_fetch();
			if (mem_cmd == mem_write)
				check_store();
			if (halted === 1'b1 && mem_cmd != mem_none) begin
				$display("Memory was accessed at address %0d while halted", mem_addr);
				error_count++;
			end
		end
		prev_cmd = mem_cmd;
		prev_addr = mem_addr;
	end

	initial begin
		int cycles;
		int limit;
		seed = 32'h9f34_d40b;
		read_data <= '0;
		error_count = 0;
		fetch_count = 0;
		store_index = 0;
		first_read_done = 1'b0;
		prev_cmd = mem_none;
		prev_addr = '0;
		mn = 1'b0;
		mv = 1'b0;
		mz = 1'b0;
		for (int a = 0; a < (1 << addr_width); a++)
			mmem[a] = fill_word(addr_width'(a));
		for (int i = 0; i <= max_prog; i++)
			flag_check[i] = 1'b0;
		for (int r = 0; r < reg_count; r++)
			mregs[r] = '0;
		build_program();
		for (int a = 0; a < (1 << addr_width); a++)
			mem[a] <= (a < prog_len) ? prog[a] : fill_word(addr_width'(a));

		limit = prog_len * 9 + 50; // worst case is three fetch and six execute cycles
		cycles = 0;
		while (halted !== 1'b1 && cycles < limit) begin
			@(negedge clk);
			cycles++;
		end

		if (halted !== 1'b1) begin
			$display("The processor never halted within %0d cycles", limit);
			error_count++;
		end else begin
			if (fetch_count != prog_len) begin
				$display("Error at %0t: halted after %0d fetches, expected %0d", $time,
					fetch_count, prog_len);
				error_count++;
			end
			repeat (halt_quiet) begin
				@(negedge clk);
				if (halted !== 1'b1) begin
					$display("Error at %0t: halted dropped before reset", $time);
					error_count++;
				end
			end
			if (store_index != exp_addr.size()) begin
				$display("Error at %0t: %0d stores seen, expected %0d", $time, store_index,
					exp_addr.size());
				error_count++;
			end
		end

		$display("Summary: %0d instructions, %0d fetches, %0d stores, %0d errors", prog_len,
			fetch_count, store_index, error_count);
		if (error_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

// File: cpu.f
cpu_pkg.sv
cpu_decoder.sv
register_file.sv
alu_shifter.sv
cpu_datapath.sv
cpu_controller.sv
cpu.sv
tb_clock.sv
tb_cpu.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tb_cpu -f cpu.f -o tb_cpu_sim

status=0
./obj_dir/tb_cpu_sim > sim.log 2>&1 || status=$?
cat sim.log

if [ "$status" -ne 0 ] || grep -qF '*** FAILED ***' sim.log; then
	echo "simulation failed"
	exit 1
fi
echo "simulation passed"
